/* hw/aes_pkg.sv */
package aes_pkg;

    // ********************
    // basic data types
    // ********************

    typedef logic [7:0]   byte_t;
    typedef logic [31:0]  word_t;
    typedef logic [127:0] block_t;   // word 0 in the top bits, byte 0 at [127:120]

    // one request: key and plaintext enter the pipeline together
    typedef struct packed {
        logic   valid;
        block_t key;
        block_t plaintext;
    } cipher_req_t;

    typedef struct packed {
        logic   valid;
        block_t ciphertext;
    } cipher_rsp_t;

    localparam int NUM_ROUNDS   = 10;
    localparam int CORE_LATENCY = 2 * NUM_ROUNDS + 1;   // whitening + two cycles per round

    // round constants, index is the key expansion round
    localparam byte_t RCON [1:NUM_ROUNDS] = '{
        8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
        8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

    // ********************
    // GF(2^8) arithmetic
    // ********************

    // multiply by x, reduce by x^8 + x^4 + x^3 + x + 1
    function automatic byte_t gf_xtime(byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // shift-and-add product
    function automatic byte_t gf_mul(byte_t a, byte_t b);
        byte_t prod;
        byte_t term;
        prod = 8'h00;
        term = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                prod = prod ^ term;
            term = gf_xtime(term);
        end
        return prod;
    endfunction

endpackage

/* hw/aes_sbox.sv */
`timescale 1ns/10ps

module aes_sbox (
    input  logic           clk,
    input  aes_pkg::byte_t in,
    output aes_pkg::byte_t out
);

    // inverse is x^254, and 254 = 8'b1111_1110
    localparam aes_pkg::byte_t INV_EXP = 8'hfe;
    localparam aes_pkg::byte_t AFF_C   = 8'h63;

    // ********************
    // field inverse
    // ********************

    // square-and-multiply over the exponent bits, lsb first
    function automatic aes_pkg::byte_t gf_inv(aes_pkg::byte_t x);
        aes_pkg::byte_t acc;
        aes_pkg::byte_t pw;
        acc = 8'h01;
        pw  = x;                                  // x^(2^i)
        for (int i = 0; i < 8; i++)
        begin
            if (INV_EXP[i])
                acc = aes_pkg::gf_mul(acc, pw);
            pw = aes_pkg::gf_mul(pw, pw);
        end
        return acc;                               // zero input gives zero
    endfunction

    // ********************
    // affine transform
    // ********************

    // b ^ rotl1 ^ rotl2 ^ rotl3 ^ rotl4 ^ 63
    function automatic aes_pkg::byte_t affine(aes_pkg::byte_t b);
        aes_pkg::byte_t r;
        r = b;
        r = r ^ {b[6:0], b[7]};
        r = r ^ {b[5:0], b[7:6]};
        r = r ^ {b[4:0], b[7:5]};
        r = r ^ {b[3:0], b[7:4]};
        return r ^ AFF_C;
    endfunction

    // one-cycle lookup, same timing as a table rom
    always_ff @(posedge clk)
    begin
        out <= affine(gf_inv(in));
    end

endmodule

/* hw/aes_key_stage.sv */
`timescale 1ns/10ps

module aes_key_stage #(
    parameter int ROUND = 1                   // 1 .. NUM_ROUNDS, picks the round constant
) (
    input  logic            clk,
    input  aes_pkg::block_t key_in,
    output aes_pkg::block_t round_key,
    output aes_pkg::block_t mix_key
);

    aes_pkg::word_t [0:3] k;                  // incoming key words, k[0] in the top bits
    aes_pkg::word_t [0:3] v;                  // prefix xor of the words
    aes_pkg::word_t [0:3] v_q;
    aes_pkg::word_t       rot;                // RotWord of the last word
    aes_pkg::byte_t [0:3] sub;                // SubWord result, registered in the S-boxes

    assign k   = key_in;
    assign rot = {k[3][23:0], k[3][31:24]};

    // ********************
    // first cycle
    // ********************

    // w0 ^ rcon, then running xor across the row of words
    always_comb
    begin
        v[0] = k[0] ^ {aes_pkg::RCON[ROUND], 24'h000000};
        for (int i = 1; i < 4; i++)
            v[i] = v[i-1] ^ k[i];
    end

    always_ff @(posedge clk)
    begin
        v_q <= v;                             // lines up with the S-box register
    end

    for (genvar j = 0; j < 4; j++)
    begin : g_sub
        aes_sbox u_sbox (
            .clk (clk),
            .in  (rot[31 - 8*j -: 8]),
            .out (sub[j])
        );
    end

    // ********************
    // second cycle
    // ********************

    // substituted word folds into every word of the prefix chain
    assign mix_key = {v_q[0] ^ sub,
                      v_q[1] ^ sub,
                      v_q[2] ^ sub,
                      v_q[3] ^ sub};

    always_ff @(posedge clk)
    begin
        round_key <= mix_key;                 // feeds the next key stage
    end

endmodule

/* hw/aes_round.sv */
`timescale 1ns/10ps

module aes_round (
    input  logic            clk,
    input  aes_pkg::block_t state_in,
    input  aes_pkg::block_t mix_key,
    output aes_pkg::block_t state_out
);

    aes_pkg::byte_t [0:15] s_in;              // byte i is column i/4, row i%4
    aes_pkg::byte_t [0:15] sb;                // S(x), registered
    aes_pkg::byte_t [0:15] sb2;               // 2 * S(x)
    aes_pkg::byte_t [0:15] sb3;               // 3 * S(x)
    aes_pkg::word_t [0:3]  col;               // MixColumns output, before the key

    assign s_in = state_in;

    // ********************
    // SubBytes
    // ********************

    for (genvar i = 0; i < 16; i++)
    begin : g_sub
        aes_sbox u_sbox (
            .clk (clk),
            .in  (s_in[i]),
            .out (sb[i])
        );

        assign sb2[i] = aes_pkg::gf_xtime(sb[i]);
        assign sb3[i] = sb2[i] ^ sb[i];
    end

    // ********************
    // ShiftRows + MixColumns
    // ********************

    for (genvar c = 0; c < 4; c++)
    begin : g_col
        // row r of output column c is taken from column c+r
        localparam int B0 = 4 * c;
        localparam int B1 = 4 * ((c + 1) % 4) + 1;
        localparam int B2 = 4 * ((c + 2) % 4) + 2;
        localparam int B3 = 4 * ((c + 3) % 4) + 3;

        // circulant 02 03 01 01
        assign col[c] = {sb2[B0] ^ sb3[B1] ^ sb[B2]  ^ sb[B3],
                         sb[B0]  ^ sb2[B1] ^ sb3[B2] ^ sb[B3],
                         sb[B0]  ^ sb[B1]  ^ sb2[B2] ^ sb3[B3],
                         sb3[B0] ^ sb[B1]  ^ sb[B2]  ^ sb2[B3]};
    end

    // AddRoundKey with the key that the matching key stage exposes this cycle
    always_ff @(posedge clk)
    begin
        state_out <= col ^ mix_key;
    end

endmodule

/* hw/aes_final_round.sv */
`timescale 1ns/10ps

module aes_final_round (
    input  logic            clk,
    input  aes_pkg::block_t state_in,
    input  aes_pkg::block_t mix_key,
    output aes_pkg::block_t state_out
);

    aes_pkg::byte_t [0:15] s_in;
    aes_pkg::byte_t [0:15] sb;                // registered SubBytes
    aes_pkg::word_t [0:3]  col;               // after ShiftRows

    assign s_in = state_in;

    for (genvar i = 0; i < 16; i++)
    begin : g_sub
        aes_sbox u_sbox (
            .clk (clk),
            .in  (s_in[i]),
            .out (sb[i])
        );
    end

    // ********************
    // ShiftRows only
    // ********************

    // no MixColumns in the last round
    for (genvar c = 0; c < 4; c++)
    begin : g_col
        assign col[c] = {sb[4 * c],
                         sb[4 * ((c + 1) % 4) + 1],
                         sb[4 * ((c + 2) % 4) + 2],
                         sb[4 * ((c + 3) % 4) + 3]};
    end

    always_ff @(posedge clk)
    begin
        state_out <= col ^ mix_key;           // last round key, ciphertext out
    end

endmodule

/* hw/aes128_core.sv */
`timescale 1ns/10ps

module aes128_core (
    input  logic                 clk,
    input  logic                 rst,
    input  aes_pkg::cipher_req_t req,
    output aes_pkg::cipher_rsp_t rsp
);

    localparam int NR  = aes_pkg::NUM_ROUNDS;
    localparam int LAT = aes_pkg::CORE_LATENCY;

    aes_pkg::block_t white_q;                 // plaintext ^ key
    aes_pkg::block_t key_q;                   // cipher key lined up with white_q
    aes_pkg::block_t state     [NR];          // state[r] leaves round r and state[0] is whitening
    aes_pkg::block_t round_key [NR];          // round_key[r] feeds key stage r+1
    aes_pkg::block_t mix_key   [1:NR];        // key used by round r in its second cycle
    aes_pkg::block_t ciphertext;
    logic [LAT-1:0]  vld_pipe;                // one flop per data register stage

    // ********************
    // input whitening
    // ********************

    always_ff @(posedge clk)
    begin
        white_q <= req.plaintext ^ req.key;
        key_q   <= req.key;
    end

    assign state[0]     = white_q;
    assign round_key[0] = key_q;

    // ********************
    // key expansion chain
    // ********************

    for (genvar r = 1; r <= NR; r++)
    begin : g_key
        if (r < NR)
        begin : g_mid
            aes_key_stage #(
                .ROUND (r)
            ) u_key (
                .clk       (clk),
                .key_in    (round_key[r-1]),
                .round_key (round_key[r]),
                .mix_key   (mix_key[r])
            );
        end
        else
        begin : g_last
            // last key only goes to the final round and feeds no further stage
            aes_key_stage #(
                .ROUND (r)
            ) u_key (
                .clk       (clk),
                .key_in    (round_key[r-1]),
                .round_key (),
                .mix_key   (mix_key[r])
            );
        end
    end

    // ********************
    // round chain
    // ********************

    for (genvar r = 1; r < NR; r++)
    begin : g_round
        aes_round u_round (
            .clk       (clk),
            .state_in  (state[r-1]),
            .mix_key   (mix_key[r]),
            .state_out (state[r])
        );
    end

    aes_final_round u_final (
        .clk       (clk),
        .state_in  (state[NR-1]),
        .mix_key   (mix_key[NR]),
        .state_out (ciphertext)
    );

    // ********************
    // valid tracking
    // ********************

    // one flag per block in flight, shifted alongside the data
    always_ff @(posedge clk)
    begin
        if (rst)
            vld_pipe <= '0;
        else
            vld_pipe <= {vld_pipe[LAT-2:0], req.valid};
    end

    assign rsp = '{valid: vld_pipe[LAT-1], ciphertext: ciphertext};

endmodule

/* bench/aes128_props.sv */
`timescale 1ns/10ps

module aes128_props (
    input logic                 clk,
    input logic                 rst,
    input aes_pkg::cipher_req_t req,
    input aes_pkg::cipher_rsp_t rsp
);

    localparam int LAT = aes_pkg::CORE_LATENCY;

    int clean_cycles = 0;                     // edges since rst was last seen high, saturates
    int fail_count   = 0;

    always @(posedge clk)
    begin
        if (rst)
            clean_cycles <= 0;
        else if (clean_cycles < LAT)
            clean_cycles <= clean_cycles + 1;
    end

    // valid line is a pure delay once the window holds no reset
    valid_delay: assert property (@(posedge clk)
        (clean_cycles >= LAT) |-> (rsp.valid == $past(req.valid, LAT)))
    else
    begin
        $error("rsp.valid is not req.valid delayed by %0d cycles", LAT);
        fail_count++;
    end

    valid_low_after_reset: assert property (@(posedge clk) rst |=> !rsp.valid)
    else
    begin
        $error("rsp.valid is high in the cycle after reset");
        fail_count++;
    end

    ciphertext_known: assert property (@(posedge clk)
        (rsp.valid === 1'b1) |-> !$isunknown(rsp.ciphertext))
    else
    begin
        $error("rsp.ciphertext has unknown bits while rsp.valid is high");
        fail_count++;
    end

endmodule

bind aes128_core aes128_props u_props (
    .clk (clk),
    .rst (rst),
    .req (req),
    .rsp (rsp)
);

/* bench/aes_model.svh */
`ifndef AES_MODEL_SVH
`define AES_MODEL_SVH

// ********************
// reference tables
// ********************

logic [7:0] alog_tbl [0:254];             // 3^i
logic [7:0] log_tbl  [0:255];             // i such that 3^i == x
logic [7:0] sbox_tbl [0:255];

// multiply by x modulo 0x11b
function automatic logic [7:0] double_byte(logic [7:0] b);
    logic [7:0] r;
    r = b << 1;
    if (b[7])
        r = r ^ 8'h1b;
    return r;
endfunction

// bit i is b[i] ^ b[i+4] ^ b[i+5] ^ b[i+6] ^ b[i+7] ^ c[i] with indices mod 8
function automatic logic [7:0] affine_map(logic [7:0] b);
    logic [7:0] r;
    for (int i = 0; i < 8; i++)
        r[i] = b[i] ^ b[(i + 4) % 8] ^ b[(i + 5) % 8] ^ b[(i + 6) % 8] ^ b[(i + 7) % 8];
    return r ^ 8'h63;
endfunction

// powers of the generator 3 give the inverse as 3^(255 - log x)
function automatic void build_model_tables();
    logic [7:0] p;
    p = 8'h01;
    for (int i = 0; i < 255; i++)
    begin
        alog_tbl[i] = p;
        log_tbl[p]  = 8'(i);
        p = p ^ double_byte(p);           // p * 3
    end
    sbox_tbl[0]   = affine_map(8'h00);    // zero has no log
    for (int x = 1; x < 256; x++)
        sbox_tbl[x] = affine_map(alog_tbl[(255 - log_tbl[x]) % 255]);
endfunction

// ********************
// AES-128 encryption
// ********************

function automatic logic [127:0] aes_encrypt(logic [127:0] key, logic [127:0] pt);
    logic [31:0]  w  [0:43];
    logic [7:0]   st [0:15];               // byte 4*c + row
    logic [7:0]   sh [0:15];
    logic [7:0]   a  [0:3];
    logic [31:0]  t;
    logic [7:0]   rc;
    logic [127:0] ct;
    for (int i = 0; i < 4; i++)
        w[i] = key[127 - 32 * i -: 32];
    rc = 8'h01;
    for (int i = 4; i < 44; i++)
    begin
        t = w[i - 1];
        if (i % 4 == 0)
        begin
            t = {sbox_tbl[t[23:16]], sbox_tbl[t[15:8]], sbox_tbl[t[7:0]], sbox_tbl[t[31:24]]};
            t[31:24] = t[31:24] ^ rc;
            rc = double_byte(rc);
        end
        w[i] = w[i - 4] ^ t;
    end
    for (int i = 0; i < 16; i++)
        st[i] = pt[127 - 8 * i -: 8] ^ w[i / 4][31 - 8 * (i % 4) -: 8];
    for (int r = 1; r <= 10; r++)
    begin
        for (int c = 0; c < 4; c++)       // SubBytes and ShiftRows
            for (int row = 0; row < 4; row++)
                sh[4 * c + row] = sbox_tbl[st[4 * ((c + row) % 4) + row]];
        for (int c = 0; c < 4; c++)
        begin
            for (int row = 0; row < 4; row++)
                a[row] = sh[4 * c + row];
            if (r < 10)
            begin
                st[4 * c]     = double_byte(a[0]) ^ double_byte(a[1]) ^ a[1] ^ a[2] ^ a[3];
                st[4 * c + 1] = a[0] ^ double_byte(a[1]) ^ double_byte(a[2]) ^ a[2] ^ a[3];
                st[4 * c + 2] = a[0] ^ a[1] ^ double_byte(a[2]) ^ double_byte(a[3]) ^ a[3];
                st[4 * c + 3] = double_byte(a[0]) ^ a[0] ^ a[1] ^ a[2] ^ double_byte(a[3]);
            end
            else
            begin
                for (int row = 0; row < 4; row++)
                    st[4 * c + row] = a[row];
            end
            for (int row = 0; row < 4; row++)
                st[4 * c + row] = st[4 * c + row] ^ w[4 * r + c][31 - 8 * row -: 8];
        end
    end
    for (int i = 0; i < 16; i++)
        ct[127 - 8 * i -: 8] = st[i];
    return ct;
endfunction

`endif

/* bench/aes_checker.sv */
`timescale 1ns/10ps

module aes_checker (
    input  logic                 clk,
    input  logic                 rst,
    input  aes_pkg::cipher_req_t req,
    input  aes_pkg::cipher_rsp_t rsp,
    input  logic                 end_check,
    output int                   error_count,
    output int                   checked_count,
    output int                   pending_count
);

    `include "aes_model.svh"

    localparam int LAT = aes_pkg::CORE_LATENCY;

    typedef struct packed {
        aes_pkg::block_t ct;
        logic [31:0]     cycle;           // edge at which the request was taken
    } expect_t;

    expect_t     exp_q [$];
    int          errors   = 0;
    int          checked  = 0;
    int          pending  = 0;
    logic [31:0] cycle_no = '0;

    assign error_count   = errors;
    assign checked_count = checked;
    assign pending_count = pending;

    // the model must reproduce FIPS-197 appendix B before it is trusted
    initial
    begin
        build_model_tables();
        if (aes_encrypt(128'h2b7e151628aed2a6abf7158809cf4f3c,
                        128'h3243f6a8885a308d313198a2e0370734)
            !== 128'h3925841d02dc09fbdc118597196a0b32)
        begin
            $display("model self-check failed, the reference model does not match FIPS-197");
            errors++;
        end
    end

    // ********************
    // compare on every edge
    // ********************

    always @(posedge clk)
    begin : watch_ports
        expect_t head;
        if (rsp.valid === 1'b1)
        begin
            if (exp_q.size() == 0)
            begin
                $display("%0t: a response came out with no request waiting for it", $time);
                errors++;
            end
            else
            begin
                head = exp_q.pop_front();
                checked++;
                if (rsp.ciphertext !== head.ct)
                begin
                    $display("ERROR %0t: rsp.ciphertext expected %h, actual %h",
                             $time, head.ct, rsp.ciphertext);
                    errors++;
                end
                if (cycle_no - head.cycle != LAT)
                begin
                    $display("%0t: response arrived %0d cycles after its request, not %0d",
                             $time, cycle_no - head.cycle, LAT);
                    errors++;
                end
            end
        end
        if (rst)
            exp_q.delete();                   // blocks in flight are dropped
        else if (req.valid === 1'b1)
            exp_q.push_back('{ct: aes_encrypt(req.key, req.plaintext), cycle: cycle_no});
        if (end_check && exp_q.size() != 0)
        begin
            $display("%0d accepted requests never got a response", exp_q.size());
            errors += exp_q.size();
            exp_q.delete();
        end
        pending = exp_q.size();
        cycle_no++;
    end

endmodule

/* bench/tb_aes128.sv */
`timescale 1ns/10ps

module tb_aes128;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_DIRECTED = 7;
    localparam int NUM_RANDOM   = 1500;
    localparam int NUM_FLUSHED  = 33;         // sent just before and during the mid-stream reset
    localparam int NUM_BURST    = 64;
    localparam int NUM_REQUESTS = NUM_DIRECTED + NUM_RANDOM + NUM_FLUSHED + NUM_BURST;
    localparam int LAT          = aes_pkg::CORE_LATENCY;
    localparam int TIMEOUT_NS   = (RESET_CYCLES + 2 * NUM_REQUESTS + 4 * LAT) * CLK_PERIOD * 2;

    logic                 clk;
    logic                 rst;
    logic                 end_check;
    aes_pkg::cipher_req_t req;
    aes_pkg::cipher_rsp_t rsp;
    int                   error_count;
    int                   checked_count;
    int                   pending_count;

    aes128_core UUT (
        .clk (clk),
        .rst (rst),
        .req (req),
        .rsp (rsp)
    );

    aes_checker u_checker (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .rsp           (rsp),
        .end_check     (end_check),
        .error_count   (error_count),
        .checked_count (checked_count),
        .pending_count (pending_count)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, the test sequence never finished", TIMEOUT_NS);
        $display("Some tests failed");
        $finish;
    end

    // ********************
    // stimulus helpers
    // ********************

    function automatic aes_pkg::block_t random_block();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    task automatic send_block(input aes_pkg::block_t key, input aes_pkg::block_t pt);
        @(posedge clk);
        req <= '{valid: 1'b1, key: key, plaintext: pt};
    endtask

    task automatic go_idle(input int cycles);
        repeat (cycles)
        begin
            @(posedge clk);
            req.valid <= 1'b0;
        end
    endtask

    task automatic wait_drained();
        @(negedge clk);
        while (pending_count != 0)
            @(negedge clk);
    endtask

    initial
    begin : run_tests
        aes_pkg::block_t same;
        void'($urandom(71994));
        rst       = 1'b1;
        end_check = 1'b0;
        req       = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // known answers and corner operands
        send_block(128'h000102030405060708090a0b0c0d0e0f, 128'h00112233445566778899aabbccddeeff);
        send_block(128'h2b7e151628aed2a6abf7158809cf4f3c, 128'h3243f6a8885a308d313198a2e0370734);
        send_block('0, '0);
        send_block('1, '1);
        same = random_block();
        send_block(same, same);               // whitening gives an all-zero state
        send_block('0, '1);
        send_block('1, '0);
        go_idle(1);
        wait_drained();

        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            send_block(random_block(), random_block());
            if ($urandom % 4 == 0)
                go_idle(1 + $urandom % 2);
        end
        go_idle(1);
        wait_drained();

        // ********************
        // reset with blocks in flight
        // ********************
        repeat (NUM_FLUSHED - 3) send_block(random_block(), random_block());
        send_block(random_block(), random_block());
        rst <= 1'b1;
        repeat (2) send_block(random_block(), random_block());
        @(posedge clk);
        rst       <= 1'b0;
        req.valid <= 1'b0;
        go_idle(LAT + 8);                     // checker flags anything that leaks out
        wait_drained();

        repeat (NUM_BURST) send_block(random_block(), random_block());
        go_idle(1);
        wait_drained();
        go_idle(LAT + 4);

        @(posedge clk);
        end_check <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        $display("%0d responses checked, %0d checker errors, %0d assertion failures",
                 checked_count, error_count, UUT.u_props.fail_count);
        if (error_count == 0 && UUT.u_props.fail_count == 0 && checked_count > 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

/* compile.f */
+incdir+bench
hw/aes_pkg.sv
hw/aes_sbox.sv
hw/aes_key_stage.sv
hw/aes_round.sv
hw/aes_final_round.sv
hw/aes128_core.sv
bench/aes128_props.sv
bench/aes_checker.sv
bench/tb_aes128.sv
